// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // --------------------
    // Widths.
    localparam int XLEN = 64;
    localparam int ALEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ALEN-1:0] addr_t;
    typedef logic [3:0]      trap_cause_t;
    typedef logic [4:0]      opcode_t;
    typedef logic [11:0]     imm12_t;

    // --------------------
    // Major opcodes, instruction bits 6:2.
    localparam opcode_t OP_LOAD     = 5'b00000;
    localparam opcode_t OP_MISC_MEM = 5'b00011;
    localparam opcode_t OP_STORE    = 5'b01000;

    // --------------------
    // Trap causes.
    localparam trap_cause_t EXC_ILLEGAL_INSTR         = 4'd2;
    localparam trap_cause_t EXC_LOAD_ADDR_MISALIGNED  = 4'd4;
    localparam trap_cause_t EXC_LOAD_ACCESS_FAULT     = 4'd5;
    localparam trap_cause_t EXC_STORE_ADDR_MISALIGNED = 4'd6;

    // Access size from funct3[1:0].
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'b00,
        SIZE_HALF  = 2'b01,
        SIZE_WORD  = 2'b10,
        SIZE_DWORD = 2'b11
    } access_size_e;

    // One memory operation as handed to the stage.
    typedef struct packed {
        opcode_t     opcode;
        logic [2:0]  funct3;
        imm12_t      i_imm;
        imm12_t      s_imm;
        xlen_t       rs1_data;
        xlen_t       rs2_data;
    } mem_op_t;

    typedef struct packed {
        logic        exception;
        trap_cause_t trap_cause;
        addr_t       fault_addr;
        xlen_t       result;     // Extended load data, zero otherwise.
    } mem_result_t;

endpackage

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int ALIGN_BITS = 3;                // Byte offset within a doubleword.

    typedef logic [core_pkg::ALEN-ALIGN_BITS-1:0] line_addr_t;
    typedef logic [core_pkg::XLEN/8-1:0]          byte_mask_t;

    // Stage to cache.
    typedef struct packed {
        line_addr_t      addr;
        logic            do_load;
        logic            do_store;
        core_pkg::xlen_t store_data;
        byte_mask_t      store_mask;
    } lsu_req_t;

    // Cache to stage.
    typedef struct packed {
        logic            stall_next;   // Low in the cycle after an accept.
        logic            access_fault;
        core_pkg::xlen_t load_data;
    } lsu_resp_t;

endpackage

`default_nettype wire

// ==== exec_mem/exec_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_mem (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire core_pkg::mem_op_t    op,
    input  wire logic                 op_valid,
    output cache_pkg::lsu_req_t       req,
    output logic                      req_stalled,
    input  wire cache_pkg::lsu_resp_t resp,
    output logic                      res_valid,
    output core_pkg::mem_result_t     res
);

    // --------------------
    // Address generation.

    logic                       store_bit;
    logic                       is_load_store;
    core_pkg::imm12_t           mem_imm;
    core_pkg::addr_t            eff_addr;
    logic [cache_pkg::ALIGN_BITS-1:0] offset_comb;
    core_pkg::access_size_e     size_comb;
    logic                       misaligned;
    logic                       issue;

    assign store_bit     = op.opcode[3];
    assign is_load_store = (op.opcode == core_pkg::OP_LOAD) ||
                           (op.opcode == core_pkg::OP_STORE);

    assign mem_imm  = store_bit ? op.s_imm : op.i_imm;
    assign eff_addr = op.rs1_data[core_pkg::ALEN-1:0] +
                      {{(core_pkg::ALEN-12){mem_imm[11]}}, mem_imm};

    assign offset_comb = eff_addr[cache_pkg::ALIGN_BITS-1:0];
    assign size_comb   = core_pkg::access_size_e'(op.funct3[1:0]);

    // Any access not aligned to its own size is rejected.
    always_comb begin
        unique case (size_comb)
            core_pkg::SIZE_BYTE:  misaligned = 1'b0;
            core_pkg::SIZE_HALF:  misaligned = offset_comb[0];
            core_pkg::SIZE_WORD:  misaligned = |offset_comb[1:0];
            core_pkg::SIZE_DWORD: misaligned = |offset_comb[2:0];
            default:              misaligned = 1'b1;
        endcase
    end

    assign issue       = op_valid && is_load_store && !misaligned;
    assign req_stalled = !issue;   // Active low issue strobe.

    // --------------------
    // Store formatting.

    core_pkg::xlen_t      store_data;
    cache_pkg::byte_mask_t store_mask;

    always_comb begin
        store_data = op.rs2_data;
        store_mask = '0;
        unique case (size_comb)
            core_pkg::SIZE_BYTE: begin
                for (int i = 0; i < 8; i++) begin
                    store_data[i*8 +: 8] = op.rs2_data[7:0];
                    store_mask[i]        = (offset_comb == i);
                end
            end
            core_pkg::SIZE_HALF: begin
                for (int i = 0; i < 4; i++) begin
                    store_data[i*16 +: 16] = op.rs2_data[15:0];
                    store_mask[i*2 +: 2]   = {2{offset_comb[2:1] == i}};
                end
            end
            core_pkg::SIZE_WORD: begin
                for (int i = 0; i < 2; i++) begin
                    store_data[i*32 +: 32] = op.rs2_data[31:0];
                    store_mask[i*4 +: 4]   = {4{offset_comb[2] == i}};
                end
            end
            default: begin
                store_data = op.rs2_data;
                store_mask = '1;
            end
        endcase
    end

    assign req.addr       = eff_addr[core_pkg::ALEN-1:cache_pkg::ALIGN_BITS];
    assign req.do_load    = !store_bit;
    assign req.do_store   = store_bit;
    assign req.store_data = store_data;
    assign req.store_mask = store_mask;

    // --------------------
    // Registered state.

    logic [cache_pkg::ALIGN_BITS-1:0] offset_q;
    core_pkg::access_size_e     size_q;
    logic                       unsigned_q;
    core_pkg::addr_t            fault_addr_q;
    logic                       exc_q;
    core_pkg::trap_cause_t      cause_q;
    logic                       single_q;   // Result comes from our own registers.

    // Kept for the load extraction of the next cycle.
    always_ff @(posedge clk) begin
        if (op_valid && is_load_store) begin
            offset_q   <= offset_comb;
            size_q     <= size_comb;
            unsigned_q <= op.funct3[2];
        end
    end

    always_ff @(posedge clk) begin
        fault_addr_q <= eff_addr;
        if (is_load_store) begin
            exc_q   <= misaligned;
            cause_q <= store_bit ? core_pkg::EXC_STORE_ADDR_MISALIGNED
                                 : core_pkg::EXC_LOAD_ADDR_MISALIGNED;
        end else if (op.opcode == core_pkg::OP_MISC_MEM) begin
            // Plain FENCE has nothing to order here.
            exc_q   <= (op.funct3 != 3'b000);
            cause_q <= core_pkg::EXC_ILLEGAL_INSTR;
        end else begin
            exc_q   <= 1'b1;
            cause_q <= core_pkg::EXC_ILLEGAL_INSTR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            single_q <= 1'b0;
        end else begin
            single_q <= op_valid && !issue;
        end
    end

    // --------------------
    // Load extraction and result select.

    logic [7:0]      loaded_byte;
    logic [15:0]     loaded_half;
    logic [31:0]     loaded_word;
    core_pkg::xlen_t loaded_data;

    assign loaded_byte = resp.load_data[offset_q*8 +: 8];
    assign loaded_half = resp.load_data[offset_q[2:1]*16 +: 16];
    assign loaded_word = resp.load_data[offset_q[2]*32 +: 32];

    always_comb begin
        loaded_data = resp.load_data;
        unique case (size_q)
            core_pkg::SIZE_BYTE:
                loaded_data = {{(core_pkg::XLEN-8){loaded_byte[7] & !unsigned_q}}, loaded_byte};
            core_pkg::SIZE_HALF:
                loaded_data = {{(core_pkg::XLEN-16){loaded_half[15] & !unsigned_q}}, loaded_half};
            core_pkg::SIZE_WORD:
                loaded_data = {{(core_pkg::XLEN-32){loaded_word[31] & !unsigned_q}}, loaded_word};
            default:
                loaded_data = resp.load_data;
        endcase
    end

    assign res_valid = single_q || !resp.stall_next;

    always_comb begin
        res.fault_addr = fault_addr_q;
        if (!resp.stall_next) begin
            res.exception  = resp.access_fault;
            res.trap_cause = core_pkg::EXC_LOAD_ACCESS_FAULT;   // Same code for stores.
            res.result     = loaded_data;
        end else begin
            res.exception  = exc_q;
            res.trap_cause = cause_q;
            res.result     = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/data_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_cache #(
    parameter int MEM_LINES = 256
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire cache_pkg::lsu_req_t req,
    input  wire logic                req_stalled,
    output cache_pkg::lsu_resp_t     resp
);

    localparam int IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

    core_pkg::xlen_t mem [MEM_LINES];

    logic             accept;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign accept   = !req_stalled;
    assign in_range = (req.addr < MEM_LINES);
    assign idx      = req.addr[IDX_W-1:0];

    // --------------------
    // Byte-masked write.

    always_ff @(posedge clk) begin
        if (accept && req.do_store && in_range) begin
            for (int b = 0; b < core_pkg::XLEN/8; b++) begin
                if (req.store_mask[b]) begin
                    mem[idx][b*8 +: 8] <= req.store_data[b*8 +: 8];
                end
            end
        end
    end

    // --------------------
    // Read and response.

    core_pkg::xlen_t rdata_q;
    logic            fault_q;
    logic            accepted_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            fault_q <= !in_range;
            // Faulting lines and stores return zero.
            rdata_q <= (req.do_load && in_range) ? mem[idx] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accepted_q <= 1'b0;
        end else begin
            accepted_q <= accept;
        end
    end

    assign resp.stall_next   = !accepted_q;
    assign resp.access_fault = fault_q;
    assign resp.load_data    = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int MEM_LINES = 256     // Cache depth in doublewords.
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire core_pkg::mem_op_t op,
    input  wire logic              op_valid,
    output logic                   res_valid,
    output core_pkg::mem_result_t  res
);

    // --------------------
    // Stage to cache.

    cache_pkg::lsu_req_t  req;
    logic                 req_stalled;
    cache_pkg::lsu_resp_t resp;

    exec_mem u_exec_mem (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .op_valid    (op_valid),
        .req         (req),
        .req_stalled (req_stalled),
        .resp        (resp),
        .res_valid   (res_valid),
        .res         (res)
    );

    data_cache #(
        .MEM_LINES (MEM_LINES)
    ) u_data_cache (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_stalled (req_stalled),
        .resp        (resp)
    );

endmodule

`default_nettype wire

// ==== verif/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    localparam int LINES     = 16;
    localparam int MAX_CYCLE = 2000;

    logic                  clk;
    logic                  rst;
    core_pkg::mem_op_t     op;
    logic                  op_valid;
    logic                  res_valid;
    core_pkg::mem_result_t res;

    core_pkg::xlen_t       shadow [LINES];          // Reference copy of the cache.
    core_pkg::mem_result_t expected [$];
    logic                  issued = 1'b0;
    int                    cycle_count = 0;
    integer                seed = 32'he9c8;

    mem_stage #(
        .MEM_LINES (LINES)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_valid  (op_valid),
        .res_valid (res_valid),
        .res       (res)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // --------------------
    // Reference model.

    function automatic core_pkg::mem_result_t ref_result(input core_pkg::mem_op_t mop);
        core_pkg::mem_result_t r;
        core_pkg::imm12_t      imm;
        core_pkg::addr_t       addr;
        logic                  is_store;
        int                    nbytes;
        int                    off;
        int                    line;
        core_pkg::xlen_t       ext;
        r        = '0;
        is_store = (mop.opcode == core_pkg::OP_STORE);
        imm      = mop.opcode[3] ? mop.s_imm : mop.i_imm;
        addr     = mop.rs1_data[31:0] + {{20{imm[11]}}, imm};
        r.fault_addr = addr;
        if (mop.opcode == core_pkg::OP_LOAD || is_store) begin
            nbytes = 1 << mop.funct3[1:0];
            off    = addr[2:0];
            line   = addr[31:3];
            if ((addr & (nbytes - 1)) != 0) begin
                r.exception  = 1'b1;
                r.trap_cause = is_store ? core_pkg::EXC_STORE_ADDR_MISALIGNED
                                        : core_pkg::EXC_LOAD_ADDR_MISALIGNED;
            end else if (addr[31:3] >= LINES) begin
                r.exception  = 1'b1;
                r.trap_cause = core_pkg::EXC_LOAD_ACCESS_FAULT;   // Stores too.
            end else if (is_store) begin
                for (int b = 0; b < nbytes; b++) begin
                    shadow[line][(off + b)*8 +: 8] = mop.rs2_data[b*8 +: 8];
                end
            end else begin
                ext = shadow[line] >> (off*8);
                for (int b = nbytes*8; b < 64; b++) begin
                    ext[b] = mop.funct3[2] ? 1'b0 : ext[nbytes*8 - 1];
                end
                r.result = ext;
            end
        end else if (!(mop.opcode == core_pkg::OP_MISC_MEM && mop.funct3 == 3'b000)) begin
            r.exception  = 1'b1;
            r.trap_cause = core_pkg::EXC_ILLEGAL_INSTR;
        end
        return r;
    endfunction

    // --------------------
    // Stimulus helpers.

    function automatic core_pkg::xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // The unused immediate holds the inverse, so a wrong select shows up.
    function automatic core_pkg::mem_op_t make_op(input core_pkg::opcode_t opc,
                                                  input logic [2:0] f3, input logic [63:0] rs1,
                                                  input logic [11:0] imm, input logic [63:0] rs2);
        core_pkg::mem_op_t m;
        m.opcode   = opc;
        m.funct3   = f3;
        m.i_imm    = opc[3] ? ~imm : imm;
        m.s_imm    = opc[3] ? imm : ~imm;
        m.rs1_data = rs1;
        m.rs2_data = rs2;
        return m;
    endfunction

    task automatic drive_op(input core_pkg::mem_op_t next_op);
        op       = next_op;
        op_valid = 1'b1;
        expected.push_back(ref_result(next_op));
        @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        op_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // --------------------
    // Comparing process, sampled at the falling edge.

    always @(posedge clk) issued <= op_valid;

    always @(negedge clk) begin
        core_pkg::mem_result_t exp;
        if (!rst) begin
            check_field("res_valid", res_valid, issued);
            if (issued) begin
                exp = expected.pop_front();
                check_field("res.exception", res.exception, exp.exception);
                check_field("res.result", res.result, exp.result);
                if (exp.exception) begin   // Cause and address only mean something on a trap.
                    check_field("res.trap_cause", res.trap_cause, exp.trap_cause);
                    check_field("res.fault_addr", res.fault_addr, exp.fault_addr);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLE) begin
            $display("Timeout after %0d cycles, the run did not finish.", cycle_count);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    // --------------------
    // Test sequence.

    initial begin
        logic [63:0] data;
        int          gap;
        int          kind;
        rst      = 1'b1;
        op       = '0;
        op_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Fill every line, then read back one per cycle.
        for (int l = 0; l < LINES; l++) begin
            drive_op(make_op(core_pkg::OP_STORE, 3'd3, 64'(l*8), 12'd0, rand64()));
        end
        for (int l = 0; l < LINES; l++) begin
            drive_op(make_op(core_pkg::OP_LOAD, 3'd3, 64'(l*8) - 8, 12'd8, 64'd0));
        end

        // Narrow stores at each aligned offset of line 3, with both sign values.
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                data = rand64();
                data[(8 << s) - 1] = off[s];
                drive_op(make_op(core_pkg::OP_STORE, 3'(s), 64'h18, 12'(off), data));
                drive_op(make_op(core_pkg::OP_LOAD, 3'(s), 64'(24 + off), 12'd0, 64'd0));
                drive_op(make_op(core_pkg::OP_LOAD, 3'(s | 4), 64'h10, 12'(8 + off), 64'd0));
            end
        end
        drive_op(make_op(core_pkg::OP_LOAD, 3'd3, 64'h18, 12'd0, 64'd0));

        // Misaligned accesses on line 5.
        for (int s = 1; s < 4; s++) begin
            for (int off = 1; off < 8; off++) begin
                if (off % (1 << s) != 0) begin
                    drive_op(make_op(core_pkg::OP_STORE, 3'(s), 64'h28, 12'(off), rand64()));
                    drive_op(make_op(core_pkg::OP_LOAD, 3'(s), 64'h28, 12'(off), 64'd0));
                end
            end
        end
        drive_op(make_op(core_pkg::OP_LOAD, 3'd3, 64'h28, 12'd0, 64'd0));

        // Beyond the last line, including a wrap below zero.
        drive_op(make_op(core_pkg::OP_STORE, 3'd3, 64'h80, 12'd0, rand64()));
        drive_op(make_op(core_pkg::OP_STORE, 3'd0, 64'h88, 12'd3, rand64()));
        drive_op(make_op(core_pkg::OP_STORE, 3'd3, 64'h0, 12'hff8, rand64()));
        drive_op(make_op(core_pkg::OP_LOAD, 3'd3, 64'h80, 12'd0, 64'd0));
        drive_op(make_op(core_pkg::OP_LOAD, 3'd2, 64'h320, 12'd4, 64'd0));
        for (int l = 0; l < LINES; l++) begin
            drive_op(make_op(core_pkg::OP_LOAD, 3'd3, 64'(l*8), 12'd0, 64'd0));
        end

        // FENCE and illegal forms.
        drive_op(make_op(core_pkg::OP_MISC_MEM, 3'd0, 64'd0, 12'd0, 64'd0));
        drive_op(make_op(core_pkg::OP_MISC_MEM, 3'd1, 64'd0, 12'd0, 64'd0));
        drive_op(make_op(core_pkg::OP_MISC_MEM, 3'd2, 64'h40, 12'd4, 64'd0));
        drive_op(make_op(5'b00100, 3'd0, 64'h8, 12'd0, 64'd0));
        drive_op(make_op(5'b01100, 3'd3, 64'h8, 12'd1, 64'd0));
        drive_op(make_op(5'b11111, 3'd7, 64'h0, 12'd0, 64'd0));

        // Random mix with occasional gaps.
        for (int n = 0; n < 300; n++) begin
            kind = $unsigned($random(seed)) % 10;
            data = {$random(seed), 32'($unsigned($random(seed)) % 160)};
            if (kind < 4) begin
                drive_op(make_op(core_pkg::OP_LOAD, 3'($unsigned($random(seed)) % 7), data,
                                 12'($random(seed) % 24), 64'd0));
            end else if (kind < 8) begin
                drive_op(make_op(core_pkg::OP_STORE, 3'($unsigned($random(seed)) % 4), data,
                                 12'($random(seed) % 24), rand64()));
            end else if (kind == 8) begin
                drive_op(make_op(core_pkg::OP_MISC_MEM, 3'($random(seed)), data,
                                 12'd0, 64'd0));
            end else begin
                drive_op(make_op(5'($random(seed)), 3'($random(seed)), data,
                                 12'($random(seed)), rand64()));
            end
            gap = $unsigned($random(seed)) % 8;
            if (gap < 2) begin
                repeat (gap + 1) idle_cycle();
            end
        end

        repeat (3) idle_cycle();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/core_pkg.sv
common/cache_pkg.sv
exec_mem/exec_mem.sv
hdl/data_cache.sv
hdl/mem_stage.sv
verif/tb_mem_stage.sv
